/* hw/controlDecoder.sv */
// Combinational decode of each step and mode into datapath strobes and index commands
`timescale 1ns/100ps

module controlDecoder (
	input  logic [seqPkg::stepWidth-1:0] step,
	input  logic [1:0]                   opMode,
	output logic                         readEn,
	output logic                         readSel,
	output logic                         loadA,
	output logic                         loadB,
	output logic                         accEn,
	output logic                         accClear,
	output logic                         accShift,
	output logic                         writeEn,
	output logic                         idxClear,
	output logic                         pairNext,
	output logic                         columnNext
);

	logic isMul;
	logic isAdd;
	logic isCopy;

	assign isMul  = (opMode == seqPkg::modeMul);
	assign isAdd  = (opMode == seqPkg::modeAdd);
	assign isCopy = (opMode == seqPkg::modeCopy);

////////////////////////////////////////////////////////////////////////////
// Strobe table
////////////////////////////////////////////////////////////////////////////

	always_comb begin
		readEn     = 1'b0;
		readSel    = seqPkg::selA;
		loadA      = 1'b0;
		loadB      = 1'b0;
		accEn      = 1'b0;
		accClear   = 1'b0;
		accShift   = 1'b0;
		writeEn    = 1'b0;
		idxClear   = 1'b0;
		pairNext   = 1'b0;
		columnNext = 1'b0;
		case (step)
			seqPkg::stepIdle: begin
				idxClear = 1'b1; // Counters start at zero
			end
			seqPkg::stepFetchA: begin
				readEn  = 1'b1;
				readSel = seqPkg::selA;
			end
			seqPkg::stepFetchB: begin
				readEn  = 1'b1;
				readSel = seqPkg::selB;
				loadA   = isMul;  // A word from previous read
				loadB   = !isMul; // Addition takes A through register B
			end
			seqPkg::stepLatch: begin
				loadB = 1'b1;
				accEn = isAdd; // A word goes in first
			end
			seqPkg::stepAcc: begin
				accEn    = 1'b1;
				accClear = isCopy;
				pairNext = isMul;
			end
			seqPkg::stepWrite: begin
				writeEn    = 1'b1;
				accShift   = !isCopy; // Carry moves down
				columnNext = 1'b1;
			end
			default: begin
				readEn = 1'b0; // Done holds everything low
			end
		endcase
	end

endmodule

/* hw/indexUnit.sv */
// Column, pair and word counters that turn index commands into read and write offsets
`timescale 1ns/100ps

module indexUnit #(
	parameter int numWords = 17
) (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            idxClear,
	input  logic                            pairNext,
	input  logic                            columnNext,
	output logic [wordPkg::offsetWidth-1:0] readOffset,
	output logic [wordPkg::offsetWidth-1:0] writeOffset,
	output logic                            lastPair,
	output logic                            columnEmpty,
	output logic                            lastColumn,
	output logic                            lastWord
);

	localparam int ow = wordPkg::offsetWidth;

	localparam logic [ow-1:0] topWord    = ow'(numWords - 1);     // Highest operand word
	localparam logic [ow-1:0] topPairCol = ow'(2 * numWords - 2); // Last column with pairs
	localparam logic [ow-1:0] highCol    = ow'(2 * numWords - 1); // Carry-only column

	if (numWords < 2 || numWords > wordPkg::maxWords) begin : gSizeCheck
		$error("indexUnit: numWords %0d outside 2..%0d", numWords, wordPkg::maxWords);
	end

	logic [ow-1:0] column;        // k, doubles as word index j
	logic [ow-1:0] pair;          // i
	logic [ow-1:0] nextLow;
	logic [ow-1:0] aOffset;
	logic [ow-1:0] bOffset;
	logic          pairSeen;      // Set once a column had more than one step of pairs
	logic          firstAfterCmd; // Cycle right after a command, the FetchA slot

////////////////////////////////////////////////////////////////////////////
// Counters
////////////////////////////////////////////////////////////////////////////

	// Lower pair bound of column k+1 is max(0, k+2-numWords)
	assign nextLow = (column >= topWord) ? column - topWord + 1'b1 : '0;

	always_ff @(posedge clk) begin
		if (rst || idxClear) begin
			column <= '0;
			pair   <= '0;
		end else if (columnNext) begin
			column <= column + 1'b1;
			pair   <= nextLow; // Restart at new column's bound
		end else if (pairNext) begin
			pair <= pair + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst || idxClear) begin
			pairSeen <= 1'b0;
		end else if (pairNext) begin
			pairSeen <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			firstAfterCmd <= 1'b0;
		end else begin
			firstAfterCmd <= idxClear | pairNext | columnNext;
		end
	end

////////////////////////////////////////////////////////////////////////////
// Offsets and loop flags
////////////////////////////////////////////////////////////////////////////

	assign aOffset = pair;
	assign bOffset = column - pair;

	// Column 0 has A and B both at offset 0, so the A side is only needed
	// once a pairNext has come by. Addition and copy never issue pairNext,
	// keep pair at 0 and so read bOffset, which is then the word index
	assign readOffset  = (pairSeen && firstAfterCmd) ? aOffset : bOffset;
	assign writeOffset = column;

	assign lastPair    = (pair == column) || (pair == topWord); // i at min(k, numWords-1)
	assign columnEmpty = (column == highCol);
	assign lastColumn  = (column == topPairCol);
	assign lastWord    = (column == topWord);

endmodule

/* hw/opSequencer.sv */
// Top of the operation sequencer, joining step controller, decoder and index unit
`timescale 1ns/100ps

module opSequencer #(
	parameter int numWords = 17
) (
	input  logic                            clk,
	input  logic                            rst,
	input  logic [1:0]                      mode,
	output logic                            done,
	output logic                            readEn,
	output logic                            readSel,
	output logic [wordPkg::offsetWidth-1:0] readOffset,
	output logic                            loadA,
	output logic                            loadB,
	output logic                            accEn,
	output logic                            accClear,
	output logic                            accShift,
	output logic                            writeEn,
	output logic [wordPkg::offsetWidth-1:0] writeOffset
);

	logic [seqPkg::stepWidth-1:0] step;
	logic [1:0]                   opMode;
	logic                         idxClear;
	logic                         pairNext;
	logic                         columnNext;
	logic                         lastPair;
	logic                         columnEmpty;
	logic                         lastColumn;
	logic                         lastWord;

////////////////////////////////////////////////////////////////////////////
// Units
////////////////////////////////////////////////////////////////////////////

	stepController u_stepController (
		.clk         (clk),
		.rst         (rst),
		.mode        (mode),
		.lastPair    (lastPair),
		.columnEmpty (columnEmpty),
		.lastColumn  (lastColumn),
		.lastWord    (lastWord),
		.step        (step),
		.opMode      (opMode),
		.done        (done)
	);

	controlDecoder u_controlDecoder (
		.step       (step),
		.opMode     (opMode),
		.readEn     (readEn),
		.readSel    (readSel),
		.loadA      (loadA),
		.loadB      (loadB),
		.accEn      (accEn),
		.accClear   (accClear),
		.accShift   (accShift),
		.writeEn    (writeEn),
		.idxClear   (idxClear),
		.pairNext   (pairNext),
		.columnNext (columnNext)
	);

	indexUnit #(
		.numWords (numWords)
	) u_indexUnit (
		.clk         (clk),
		.rst         (rst),
		.idxClear    (idxClear),
		.pairNext    (pairNext),
		.columnNext  (columnNext),
		.readOffset  (readOffset),
		.writeOffset (writeOffset),
		.lastPair    (lastPair),
		.columnEmpty (columnEmpty),
		.lastColumn  (lastColumn),
		.lastWord    (lastWord)
	);

endmodule

/* hw/seqPkg.sv */
// Mode codes, operand selects and step encoding used by the sequencer units and testbench
package seqPkg;

////////////////////////////////////////////////////////////////////////////
// Operation modes on the mode input
////////////////////////////////////////////////////////////////////////////

	localparam logic [1:0] modeMul  = 2'd0; // Schoolbook product, column order
	localparam logic [1:0] modeSqr  = 2'd1; // No sequence, ends at once
	localparam logic [1:0] modeAdd  = 2'd2; // Word by word with carry
	localparam logic [1:0] modeCopy = 2'd3; // Word by word through accumulator

////////////////////////////////////////////////////////////////////////////
// Operand select on readSel
////////////////////////////////////////////////////////////////////////////

	localparam logic selA = 1'b0;
	localparam logic selB = 1'b1;

////////////////////////////////////////////////////////////////////////////
// Step codes, one step per cycle
////////////////////////////////////////////////////////////////////////////

	localparam int stepWidth = 4;

	localparam logic [stepWidth-1:0] stepIdle   = 4'd0; // Mode sampled here
	localparam logic [stepWidth-1:0] stepFetchA = 4'd1; // Read A word
	localparam logic [stepWidth-1:0] stepFetchB = 4'd2; // Read B word
	localparam logic [stepWidth-1:0] stepLatch  = 4'd3; // Capture last read
	localparam logic [stepWidth-1:0] stepAcc    = 4'd4; // Accumulate
	localparam logic [stepWidth-1:0] stepWrite  = 4'd5; // Store low word
	localparam logic [stepWidth-1:0] stepDone   = 4'd6; // Held until reset

endpackage

/* hw/stepController.sv */
// Step register and next-step choice that walk the per-mode loops up to a held done level
`timescale 1ns/100ps

module stepController (
	input  logic                          clk,
	input  logic                          rst,
	input  logic [1:0]                    mode,
	input  logic                          lastPair,
	input  logic                          columnEmpty,
	input  logic                          lastColumn,
	input  logic                          lastWord,
	output logic [seqPkg::stepWidth-1:0]  step,
	output logic [1:0]                    opMode,
	output logic                          done
);

	logic [seqPkg::stepWidth-1:0] nextStep;

////////////////////////////////////////////////////////////////////////////
// Step and mode registers
////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			step   <= seqPkg::stepIdle;
			opMode <= seqPkg::modeMul;
		end else begin
			step <= nextStep;
			if (step == seqPkg::stepIdle) begin
				opMode <= mode; // Only sample of mode
			end
		end
	end

////////////////////////////////////////////////////////////////////////////
// Next step
////////////////////////////////////////////////////////////////////////////

	always_comb begin
		nextStep = seqPkg::stepDone;
		case (step)
			seqPkg::stepIdle: begin
				if (mode == seqPkg::modeSqr) begin
					nextStep = seqPkg::stepDone; // Nothing to issue
				end else begin
					nextStep = seqPkg::stepFetchA;
				end
			end
			seqPkg::stepFetchA: begin
				if (opMode == seqPkg::modeCopy) begin
					nextStep = seqPkg::stepLatch; // Copy has no B operand
				end else begin
					nextStep = seqPkg::stepFetchB;
				end
			end
			seqPkg::stepFetchB: nextStep = seqPkg::stepLatch;
			seqPkg::stepLatch:  nextStep = seqPkg::stepAcc;
			seqPkg::stepAcc: begin
				if (opMode == seqPkg::modeMul && !lastPair) begin
					nextStep = seqPkg::stepFetchA; // More pairs in this column
				end else begin
					nextStep = seqPkg::stepWrite;
				end
			end
			seqPkg::stepWrite: begin
				if (opMode == seqPkg::modeMul) begin
					if (columnEmpty) begin
						nextStep = seqPkg::stepDone; // High word written
					end else if (lastColumn) begin
						nextStep = seqPkg::stepWrite; // Only the carry is left
					end else begin
						nextStep = seqPkg::stepFetchA;
					end
				end else if (lastWord) begin
					nextStep = seqPkg::stepDone;
				end else begin
					nextStep = seqPkg::stepFetchA;
				end
			end
			seqPkg::stepDone: nextStep = seqPkg::stepDone; // Left only by reset
			default:          nextStep = seqPkg::stepDone;
		endcase
	end

	assign done = (step == seqPkg::stepDone);

endmodule

/* hw/wordPkg.sv */
// Operand word geometry shared by the sequencer RTL and its testbench
package wordPkg;

////////////////////////////////////////////////////////////////////////////
// Operand size
////////////////////////////////////////////////////////////////////////////

	// Longest operand, in words, that the offsets can still address
	localparam int maxWords = 32;

	// Product words run up to offset 2*maxWords-1, so this covers the whole product
	localparam int offsetWidth = $clog2(2 * maxWords);

endpackage

/* sim.f */
hw/wordPkg.sv
hw/seqPkg.sv
hw/indexUnit.sv
hw/stepController.sv
hw/controlDecoder.sv
hw/opSequencer.sv
sim/opSequencer_props.sv
sim/opSequencer_tb.sv

/* sim/opSequencer_props.sv */
// Concurrent checks on strobe ordering and the done level, bound into the sequencer top
`timescale 1ns/100ps

module opSequencer_props (
	input logic clk,
	input logic rst,
	input logic readEn,
	input logic loadA,
	input logic loadB,
	input logic writeEn,
	input logic done
);

	int failures = 0; // Read by the testbench at the end

	// Each load captures the word read one cycle before
	loadAAfterRead: assert property (@(posedge clk) disable iff (rst) loadA |-> $past(readEn))
		else begin
			$error("loadA without a read in the previous cycle");
			failures++;
		end

	loadBAfterRead: assert property (@(posedge clk) disable iff (rst) loadB |-> $past(readEn))
		else begin
			$error("loadB without a read in the previous cycle");
			failures++;
		end

	readThenLoad: assert property (@(posedge clk) disable iff (rst) readEn |=> (loadA || loadB))
		else begin
			$error("read not followed by a load");
			failures++;
		end

	noReadOnWrite: assert property (@(posedge clk) disable iff (rst) !(readEn && writeEn))
		else begin
			$error("readEn and writeEn high together");
			failures++;
		end

	// Only reset ends the done level
	doneHolds: assert property (@(posedge clk) $fell(done) |-> $past(rst))
		else begin
			$error("done fell without reset");
			failures++;
		end

endmodule

bind opSequencer opSequencer_props u_opSequencer_props (
	.clk     (clk),
	.rst     (rst),
	.readEn  (readEn),
	.loadA   (loadA),
	.loadB   (loadB),
	.writeEn (writeEn),
	.done    (done)
);

/* sim/opSequencer_tb.sv */
// Testbench for the operation sequencer, random modes checked against a strobe stream model
`timescale 1ns/100ps

module opSequencer_tb;

	localparam int numWords      = 17;
	localparam int numRuns       = 24;
	localparam int resetCycles   = 2;
	localparam int holdCycles    = 3;  // Cycles done is watched after it rises
	localparam int halfPeriod    = 4;
	localparam int ow            = wordPkg::offsetWidth;
	localparam int slotWidth     = 2 * ow + 8;
	localparam int timeoutCycles = numRuns * (4 * numWords * numWords + 2 * numWords + 8);
	localparam logic [31:0] lfsrSeed = 32'hf592;

	logic          clk;
	logic          rst;
	logic [1:0]    mode;
	logic          done;
	logic          readEn;
	logic          readSel;
	logic [ow-1:0] readOffset;
	logic          loadA;
	logic          loadB;
	logic          accEn;
	logic          accClear;
	logic          accShift;
	logic          writeEn;
	logic [ow-1:0] writeOffset;

	logic [slotWidth-1:0] expQ[$]; // One entry per cycle between idle and done
	logic [31:0]          lfsrState;
	int                   errorCount;
	int                   checkCount;
	int                   runIdx;
	int                   runCycle;
	int                   modeRuns[4];
	int                   cycleCount;

	opSequencer #(
		.numWords (numWords)
	) u_opSequencer (
		.clk         (clk),
		.rst         (rst),
		.mode        (mode),
		.done        (done),
		.readEn      (readEn),
		.readSel     (readSel),
		.readOffset  (readOffset),
		.loadA       (loadA),
		.loadB       (loadB),
		.accEn       (accEn),
		.accClear    (accClear),
		.accShift    (accShift),
		.writeEn     (writeEn),
		.writeOffset (writeOffset)
	);

	always #(halfPeriod) clk = ~clk;

////////////////////////////////////////////////////////////////////////////
// Random numbers and reference model
////////////////////////////////////////////////////////////////////////////

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] nextLfsr(input logic [31:0] state);
		logic feedback;
		feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
		return {state[30:0], feedback};
	endfunction

	task automatic drawBits(input int count, output logic [31:0] value);
		value = '0;
		for (int b = 0; b < count; b++) begin
			lfsrState = nextLfsr(lfsrState); // One step per bit
			value     = {value[30:0], lfsrState[0]};
		end
	endtask

	function automatic int expLatency(input logic [1:0] opCode);
		case (opCode)
			seqPkg::modeMul:  return 4 * numWords * numWords + 2 * numWords;
			seqPkg::modeAdd:  return 5 * numWords;
			seqPkg::modeCopy: return 4 * numWords;
			default:          return 0;
		endcase
	endfunction

	function automatic string modeName(input logic [1:0] opCode);
		case (opCode)
			seqPkg::modeMul:  return "mul";
			seqPkg::modeAdd:  return "add";
			seqPkg::modeCopy: return "copy";
			default:          return "sqr";
		endcase
	endfunction

	task automatic pushSlot(input logic rdEn, input logic rdSel, input int rdOff,
			input logic ldA, input logic ldB, input logic accOn, input logic accClr,
			input logic accSh, input logic wrEn, input int wrOff);
		expQ.push_back({rdEn, rdSel, ow'(rdOff), ldA, ldB, accOn, accClr, accSh, wrEn,
			ow'(wrOff)});
	endtask

	task automatic buildExpected(input logic [1:0] opCode);
		int lo;
		int hi;
		expQ.delete();
		case (opCode)
			seqPkg::modeMul: begin
				for (int k = 0; k < 2 * numWords - 1; k++) begin
					lo = (k > numWords - 1) ? k - numWords + 1 : 0; // Pair bounds of column k
					hi = (k < numWords - 1) ? k : numWords - 1;
					for (int i = lo; i <= hi; i++) begin
						pushSlot(1, seqPkg::selA, i, 0, 0, 0, 0, 0, 0, 0);     // FetchA
						pushSlot(1, seqPkg::selB, k - i, 1, 0, 0, 0, 0, 0, 0); // FetchB
						pushSlot(0, seqPkg::selA, 0, 0, 1, 0, 0, 0, 0, 0);     // Latch
						pushSlot(0, seqPkg::selA, 0, 0, 0, 1, 0, 0, 0, 0);     // Acc
					end
					pushSlot(0, seqPkg::selA, 0, 0, 0, 0, 0, 1, 1, k); // Column write
				end
				pushSlot(0, seqPkg::selA, 0, 0, 0, 0, 0, 1, 1, 2 * numWords - 1); // High word
			end
			seqPkg::modeAdd: begin
				for (int j = 0; j < numWords; j++) begin
					pushSlot(1, seqPkg::selA, j, 0, 0, 0, 0, 0, 0, 0);
					pushSlot(1, seqPkg::selB, j, 0, 1, 0, 0, 0, 0, 0);
					pushSlot(0, seqPkg::selA, 0, 0, 1, 1, 0, 0, 0, 0);
					pushSlot(0, seqPkg::selA, 0, 0, 0, 1, 0, 0, 0, 0);
					pushSlot(0, seqPkg::selA, 0, 0, 0, 0, 0, 1, 1, j);
				end
			end
			seqPkg::modeCopy: begin
				for (int j = 0; j < numWords; j++) begin
					pushSlot(1, seqPkg::selA, j, 0, 0, 0, 0, 0, 0, 0);
					pushSlot(0, seqPkg::selA, 0, 0, 1, 0, 0, 0, 0, 0);
					pushSlot(0, seqPkg::selA, 0, 0, 0, 1, 1, 0, 0, 0);
					pushSlot(0, seqPkg::selA, 0, 0, 0, 0, 0, 0, 1, j); // No carry shift
				end
			end
			default: begin
			end
		endcase
	endtask

////////////////////////////////////////////////////////////////////////////
// Checks
////////////////////////////////////////////////////////////////////////////

	task automatic checkValue(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checkCount++;
		assert (got === exp) else begin
			$display("FAIL %s: got 0x%0h, expected 0x%0h (run %0d, cycle %0d)",
				name, got, exp, runIdx, runCycle);
			errorCount++;
		end
	endtask

	task automatic checkQuiet(input logic expDone);
		checkValue("readEn", readEn, 0);
		checkValue("loadA", loadA, 0);
		checkValue("loadB", loadB, 0);
		checkValue("accEn", accEn, 0);
		checkValue("accClear", accClear, 0);
		checkValue("accShift", accShift, 0);
		checkValue("writeEn", writeEn, 0);
		checkValue("done", done, expDone);
	endtask

	task automatic compareCycle(input logic [slotWidth-1:0] expSlot);
		logic          eRdEn;
		logic          eRdSel;
		logic [ow-1:0] eRdOff;
		logic          eLdA;
		logic          eLdB;
		logic          eAccOn;
		logic          eAccClr;
		logic          eAccSh;
		logic          eWrEn;
		logic [ow-1:0] eWrOff;
		{eRdEn, eRdSel, eRdOff, eLdA, eLdB, eAccOn, eAccClr, eAccSh, eWrEn, eWrOff} = expSlot;
		checkValue("readEn", readEn, eRdEn);
		if (eRdEn) begin
			checkValue("readSel", readSel, eRdSel);
			checkValue("readOffset", readOffset, eRdOff);
		end
		checkValue("loadA", loadA, eLdA);
		checkValue("loadB", loadB, eLdB);
		checkValue("accEn", accEn, eAccOn);
		checkValue("accClear", accClear, eAccClr);
		checkValue("accShift", accShift, eAccSh);
		checkValue("writeEn", writeEn, eWrEn);
		if (eWrEn) begin
			checkValue("writeOffset", writeOffset, eWrOff);
		end
	endtask

////////////////////////////////////////////////////////////////////////////
// Runs
////////////////////////////////////////////////////////////////////////////

	// Starts and ends on a falling edge
	task automatic runOperation(input int run);
		logic [31:0] bits;
		logic [1:0]  runMode;
		int          errorsBefore;
		logic        overrun;
		runIdx       = run;
		runCycle     = 0;
		overrun      = 1'b0;
		errorsBefore = errorCount;
		drawBits(2, bits);
		runMode = bits[1:0];
		modeRuns[runMode]++;
		buildExpected(runMode);
		rst  = 1'b1;
		mode = runMode;
		repeat (resetCycles) begin
			@(negedge clk);
			checkQuiet(1'b0); // Last one also stands for the idle cycle
		end
		rst = 1'b0;
		@(negedge clk);
		while (!done) begin
			if (expQ.size() > 0) begin
				compareCycle(expQ.pop_front());
			end else if (!overrun) begin
				$display("Run %0d: sequencer still busy after the expected stream ended", run);
				errorCount++;
				overrun = 1'b1;
			end
			runCycle++;
			drawBits(2, bits);
			mode = bits[1:0]; // Latched mode must ignore this
			@(negedge clk);
		end
		if (expQ.size() > 0) begin
			$display("Run %0d: done rose with %0d strobe cycles still expected", run, expQ.size());
			errorCount++;
		end
		checkValue("latency", runCycle, expLatency(runMode));
		checkQuiet(1'b1);
		repeat (holdCycles) begin
			drawBits(2, bits);
			mode = bits[1:0];
			@(negedge clk);
			checkQuiet(1'b1); // Done holds until reset
		end
		$display("Run %0d %s: %0d cycles to done, %0d errors", run, modeName(runMode),
			runCycle, errorCount - errorsBefore);
	endtask

	initial begin : watchdog
		for (cycleCount = 0; cycleCount < timeoutCycles; cycleCount++) begin
			@(posedge clk);
		end
		$display("Timeout: runs not finished after %0d cycles", timeoutCycles);
		$display("*** TEST FAILED ***");
		$finish;
	end

	initial begin : mainFlow
		int propFailures;
		clk        = 1'b0;
		rst        = 1'b1;
		mode       = seqPkg::modeMul;
		lfsrState  = lfsrSeed;
		errorCount = 0;
		checkCount = 0;
		modeRuns   = '{default: 0};
		@(negedge clk);
		for (int run = 0; run < numRuns; run++) begin
			runOperation(run);
		end
		propFailures = u_opSequencer.u_opSequencer_props.failures;
		$display("Runs %0d (mul %0d, sqr %0d, add %0d, copy %0d), checks %0d, errors %0d, %s %0d",
			numRuns, modeRuns[0], modeRuns[1], modeRuns[2], modeRuns[3], checkCount,
			errorCount, "property failures", propFailures);
		if (errorCount == 0 && propFailures == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule
